// File: clk_pkg.sv
`default_nettype none

package clk_pkg;

  // divider chain and reconfiguration table sizes.
  localparam int num_stages = 5;
  localparam int num_cfg    = 4;
  localparam int num_reg    = 4;

  // DRP port widths.
  localparam int drp_aw = 5;
  localparam int drp_dw = 16;

  // first PLL register rewritten by the table.
  localparam int rom_base = 8;

  typedef logic [drp_aw-1:0]          drp_addr_t;
  typedef logic [drp_dw-1:0]          drp_data_t;
  typedef logic [$clog2(num_cfg)-1:0] cfg_sel_t;
  typedef logic [$clog2(num_reg)-1:0] reg_idx_t;
  typedef logic [num_stages-1:0]      stage_lvl_t;

  typedef struct packed {
    logic      den;
    logic      dwe;
    drp_addr_t daddr;
    drp_data_t di;
  } drp_req_t;

  typedef struct packed {
    logic      drdy;
    drp_data_t dout;
  } drp_rsp_t;

  // bits set in keep are taken from the old register contents.
  typedef struct packed {
    drp_addr_t daddr;
    drp_data_t keep;
    drp_data_t value;
  } rom_entry_t;

  typedef enum logic [2:0] {
    idle,
    rst_assert,
    rd_issue,
    rd_wait,
    wr_issue,
    wr_wait,
    rst_release,
    lock_wait
  } drp_state_t;

endpackage

`default_nettype wire

// File: lock_sync.sv
`timescale 1ns/1ps
`default_nettype none

module lock_sync (
  input  logic CLKS,
  input  logic RSTXS,
  input  logic pll_lock,
  output logic run,
  output logic base_tick
);

  logic lock_d1;

  // a low lock sample clears both flops at once.
  always_ff @(posedge CLKS or negedge RSTXS) begin
    if (!RSTXS) begin
      lock_d1 <= 1'b0;
      run     <= 1'b0;
    end else begin
      lock_d1 <= pll_lock;
      run     <= pll_lock & lock_d1;
    end
  end

  // the chain counts every cycle of run from zero.
  assign base_tick = run;

endmodule

`default_nettype wire

// File: div_stage.sv
`timescale 1ns/1ps
`default_nettype none

module div_stage (
  input  logic CLKS,
  input  logic RSTXS,
  input  logic run,
  input  logic tick_in,
  output logic level,
  output logic tick_out
);

  always_ff @(posedge CLKS or negedge RSTXS) begin
    if (!RSTXS) begin
      level <= 1'b0;
    end else if (!run) begin
      level <= 1'b0;
    end else if (tick_in) begin
      level <= ~level;
    end
  end

  // carry to the next stage when this one wraps from 1 to 0.
  assign tick_out = tick_in & level;

endmodule

`default_nettype wire

// File: slow_rst_gen.sv
`timescale 1ns/1ps
`default_nettype none

module slow_rst_gen import clk_pkg::*; (
  input  logic       CLKS,
  input  logic       RSTXS,
  input  logic       run,
  input  stage_lvl_t stage_lvl,
  output stage_lvl_t div_lvl,
  output logic       rstx_slow
);

  logic last_lvl;
  logic last_lvl_d;
  logic last_rise;
  logic seen_rise;
  logic rstx_q;

  assign last_lvl  = stage_lvl[num_stages-1];
  assign last_rise = last_lvl & ~last_lvl_d;

  // release follows the second rising edge of the slowest level.
  // with five stages the edges come at counts 16 and 48, so rstx_q rises at 49.
  always_ff @(posedge CLKS or negedge RSTXS) begin
    if (!RSTXS) begin
      last_lvl_d <= 1'b0;
      seen_rise  <= 1'b0;
      rstx_q     <= 1'b0;
    end else if (!run) begin
      last_lvl_d <= 1'b0;
      seen_rise  <= 1'b0;
      rstx_q     <= 1'b0;
    end else begin
      last_lvl_d <= last_lvl;
      if (last_rise) begin
        seen_rise <= 1'b1;
        if (seen_rise) begin
          rstx_q <= 1'b1;
        end
      end
    end
  end

  // run low pulls the slow reset at once.
  assign rstx_slow = rstx_q & run;
  assign div_lvl   = stage_lvl;

endmodule

`default_nettype wire

// File: drp_rom.sv
`timescale 1ns/1ps
`default_nettype none

module drp_rom import clk_pkg::*; (
  input  cfg_sel_t   cfg,
  input  reg_idx_t   idx,
  output rom_entry_t entry
);

  drp_data_t keep;
  drp_data_t value;

  always_comb begin
    case ({cfg, idx})
      // configuration 0.
      4'h0: begin keep = 16'hf000; value = 16'h0041; end
      4'h1: begin keep = 16'hff00; value = 16'h0082; end
      4'h2: begin keep = 16'h00ff; value = 16'h1000; end
      4'h3: begin keep = 16'hc03f; value = 16'h0c40; end
      // configuration 1.
      4'h4: begin keep = 16'hf000; value = 16'h0083; end
      4'h5: begin keep = 16'hff00; value = 16'h00c3; end
      4'h6: begin keep = 16'h00ff; value = 16'h2100; end
      4'h7: begin keep = 16'hc03f; value = 16'h1880; end
      // configuration 2.
      4'h8: begin keep = 16'hf000; value = 16'h0104; end
      4'h9: begin keep = 16'hff00; value = 16'h0041; end
      4'ha: begin keep = 16'h00ff; value = 16'h0800; end
      4'hb: begin keep = 16'hc03f; value = 16'h0600; end
      // configuration 3.
      4'hc: begin keep = 16'hf000; value = 16'h0208; end
      4'hd: begin keep = 16'hff00; value = 16'h0020; end
      4'he: begin keep = 16'h00ff; value = 16'h4300; end
      4'hf: begin keep = 16'hc03f; value = 16'h3000; end
      default: begin
        keep  = 16'hffff;
        value = 16'h0000;
      end
    endcase
  end

  // register index i sits at the same address in every configuration.
  assign entry.daddr = drp_addr_t'(rom_base) + drp_addr_t'(idx);
  assign entry.keep  = keep;
  assign entry.value = value;

endmodule

`default_nettype wire

// File: drp_seq.sv
`timescale 1ns/1ps
`default_nettype none

module drp_seq import clk_pkg::*; (
  input  logic       CLKS,
  input  logic       RSTXS,
  input  cfg_sel_t   cfg_sel,
  input  logic       cfg_chg,
  input  logic       pll_lock,
  input  rom_entry_t entry,
  output cfg_sel_t   rom_cfg,
  output reg_idx_t   rom_idx,
  output drp_req_t   drp_req,
  input  drp_rsp_t   drp_rsp,
  output logic       rst_pll,
  output logic       cfg_busy
);

  drp_state_t state;
  cfg_sel_t   cfg_q;
  reg_idx_t   idx;
  drp_data_t  wr_data;
  logic       last_idx;

  assign last_idx = (idx == reg_idx_t'(num_reg - 1));

  always_ff @(posedge CLKS or negedge RSTXS) begin
    if (!RSTXS) begin
      state    <= idle;
      cfg_q    <= '0;
      idx      <= '0;
      rst_pll  <= 1'b0;
      cfg_busy <= 1'b0;
    end else begin
      case (state)
        idle: begin
          // strobes only count here, so a strobe during a sequence is dropped.
          if (cfg_chg) begin
            cfg_q    <= cfg_sel;
            idx      <= '0;
            rst_pll  <= 1'b1;
            cfg_busy <= 1'b1;
            state    <= rst_assert;
          end
        end
        rst_assert: begin
          state <= rd_issue;
        end
        rd_issue: begin
          state <= rd_wait;
        end
        rd_wait: begin
          if (drp_rsp.drdy) begin
            state <= wr_issue;
          end
        end
        wr_issue: begin
          state <= wr_wait;
        end
        wr_wait: begin
          if (drp_rsp.drdy) begin
            if (last_idx) begin
              state <= rst_release;
            end else begin
              idx   <= idx + 1'b1;
              state <= rd_issue;
            end
          end
        end
        rst_release: begin
          rst_pll <= 1'b0;
          state   <= lock_wait;
        end
        lock_wait: begin
          if (pll_lock) begin
            cfg_busy <= 1'b0;
            state    <= idle;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // merge the read word with the table entry for the write back.
  always_ff @(posedge CLKS) begin
    if (state == rd_wait && drp_rsp.drdy) begin
      wr_data <= (drp_rsp.dout & entry.keep) | entry.value;
    end
  end

  assign rom_cfg = cfg_q;
  assign rom_idx = idx;

  always_comb begin
    drp_req.den   = (state == rd_issue) || (state == wr_issue);
    drp_req.dwe   = (state == wr_issue);
    drp_req.daddr = entry.daddr;
    drp_req.di    = wr_data;
  end

endmodule

`default_nettype wire

// File: clk_rst_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module clk_rst_ctrl import clk_pkg::*; (
  input  logic       CLKS,
  input  logic       RSTXS,
  input  logic       pll_lock,
  input  cfg_sel_t   cfg_sel,
  input  logic       cfg_chg,
  output drp_req_t   drp_req,
  input  drp_rsp_t   drp_rsp,
  output logic       rst_pll,
  output logic       cfg_busy,
  output logic       run,
  output stage_lvl_t div_lvl,
  output logic       rstx_slow
);

  // the top bit is the carry out of the whole chain.
  logic [num_stages:0] tick;
  stage_lvl_t          stage_lvl;
  rom_entry_t          entry;
  cfg_sel_t            rom_cfg;
  reg_idx_t            rom_idx;

  lock_sync u_lock_sync (
    .CLKS      (CLKS),
    .RSTXS     (RSTXS),
    .pll_lock  (pll_lock),
    .run       (run),
    .base_tick (tick[0])
  );

  for (genvar k = 0; k < num_stages; k++) begin : g_stage
    div_stage u_div_stage (
      .CLKS     (CLKS),
      .RSTXS    (RSTXS),
      .run      (run),
      .tick_in  (tick[k]),
      .level    (stage_lvl[k]),
      .tick_out (tick[k+1])
    );
  end

  slow_rst_gen u_slow_rst_gen (
    .CLKS      (CLKS),
    .RSTXS     (RSTXS),
    .run       (run),
    .stage_lvl (stage_lvl),
    .div_lvl   (div_lvl),
    .rstx_slow (rstx_slow)
  );

  drp_rom u_drp_rom (
    .cfg   (rom_cfg),
    .idx   (rom_idx),
    .entry (entry)
  );

  drp_seq u_drp_seq (
    .CLKS     (CLKS),
    .RSTXS    (RSTXS),
    .cfg_sel  (cfg_sel),
    .cfg_chg  (cfg_chg),
    .pll_lock (pll_lock),
    .entry    (entry),
    .rom_cfg  (rom_cfg),
    .rom_idx  (rom_idx),
    .drp_req  (drp_req),
    .drp_rsp  (drp_rsp),
    .rst_pll  (rst_pll),
    .cfg_busy (cfg_busy)
  );

endmodule

`default_nettype wire

// File: clk_rst_ctrl_chk.sv
`timescale 1ns/1ps
`default_nettype none

module clk_rst_ctrl_chk import clk_pkg::*; (
  input logic     CLKS,
  input logic     RSTXS,
  input drp_req_t drp_req,
  input drp_rsp_t drp_rsp,
  input logic     rst_pll,
  input logic     cfg_busy
);

  // an access stays open from den up to and including its drdy.
  logic open_q;
  int   fail_cnt = 0;

  always_ff @(posedge CLKS or negedge RSTXS) begin
    if (!RSTXS) begin
      open_q <= 1'b0;
    end else if (drp_req.den) begin
      open_q <= 1'b1;
    end else if (drp_rsp.drdy) begin
      open_q <= 1'b0;
    end
  end

  den_single: assert property (@(posedge CLKS) disable iff (!RSTXS)
    drp_req.den |=> !drp_req.den)
    else begin
      $error("den held high for more than one cycle");
      fail_cnt++;
    end

  dwe_with_den: assert property (@(posedge CLKS) disable iff (!RSTXS)
    drp_req.dwe |-> drp_req.den)
    else begin
      $error("dwe high without den");
      fail_cnt++;
    end

  one_open: assert property (@(posedge CLKS) disable iff (!RSTXS)
    drp_req.den |-> !open_q)
    else begin
      $error("den issued while an access is outstanding");
      fail_cnt++;
    end

  rst_over_access: assert property (@(posedge CLKS) disable iff (!RSTXS)
    (drp_req.den || open_q) |-> rst_pll)
    else begin
      $error("PLL reset low during a DRP access");
      fail_cnt++;
    end

  busy_over_rst: assert property (@(posedge CLKS) disable iff (!RSTXS)
    rst_pll |-> cfg_busy)
    else begin
      $error("PLL reset high outside a reconfiguration");
      fail_cnt++;
    end

endmodule

bind drp_seq clk_rst_ctrl_chk u_chk (
  .CLKS     (CLKS),
  .RSTXS    (RSTXS),
  .drp_req  (drp_req),
  .drp_rsp  (drp_rsp),
  .rst_pll  (rst_pll),
  .cfg_busy (cfg_busy)
);

`default_nettype wire

// File: tb_clk_rst_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_rst_ctrl import clk_pkg::*; ();

  localparam int reset_cycles = 10;
  localparam int lock_delay   = 20;
  localparam int div_cycles   = 200;
  localparam int num_reconf   = 12;
  localparam int max_gap      = 127;
  localparam int acc_cycles   = 5;
  localparam int tail_cycles  = 120;
  // gap, a dropped strobe, two accesses per register, the lock delay and some slack.
  localparam int seq_cycles   = max_gap + 16 + 2 * num_reg * acc_cycles + lock_delay + 8;
  localparam int max_cycles   = reset_cycles + lock_delay + div_cycles
                                + num_reconf * seq_cycles + tail_cycles + 16;

  logic       CLKS;
  logic       RSTXS;
  logic       pll_lock;
  cfg_sel_t   cfg_sel;
  logic       cfg_chg;
  drp_req_t   drp_req;
  drp_rsp_t   drp_rsp;
  logic       rst_pll;
  logic       cfg_busy;
  logic       run;
  stage_lvl_t div_lvl;
  logic       rstx_slow;

  logic [31:0] lfsr;
  int          cyc;
  int          errors;
  // behavioral PLL.
  drp_data_t   pll_regs [32];
  int          pend;
  logic        pend_we;
  drp_addr_t   pend_addr;
  drp_data_t   pend_di;
  drp_data_t   pend_dout;
  int          lock_cnt;
  int          den_cnt;
  // reference model.
  drp_data_t   m_regs [32];
  int          m_hi;
  logic        m_run;
  int          m_cnt;
  int          m_cnt_last;
  int          m_rises;
  logic        m_rel;
  int          accepted;

  clk_rst_ctrl dut (
    .CLKS      (CLKS),
    .RSTXS     (RSTXS),
    .pll_lock  (pll_lock),
    .cfg_sel   (cfg_sel),
    .cfg_chg   (cfg_chg),
    .drp_req   (drp_req),
    .drp_rsp   (drp_rsp),
    .rst_pll   (rst_pll),
    .cfg_busy  (cfg_busy),
    .run       (run),
    .div_lvl   (div_lvl),
    .rstx_slow (rstx_slow)
  );

  always #2 CLKS = ~CLKS;

  // taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic int rand_bits(input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = (r << 1) | int'(lfsr[0]);
    end
    return r;
  endfunction

  // keep mask in the upper half and value in the lower half.
  function automatic logic [31:0] table_entry(input int c, input int i);
    case (c * num_reg + i)
      0:  return {16'hf000, 16'h0041};
      1:  return {16'hff00, 16'h0082};
      2:  return {16'h00ff, 16'h1000};
      3:  return {16'hc03f, 16'h0c40};
      4:  return {16'hf000, 16'h0083};
      5:  return {16'hff00, 16'h00c3};
      6:  return {16'h00ff, 16'h2100};
      7:  return {16'hc03f, 16'h1880};
      8:  return {16'hf000, 16'h0104};
      9:  return {16'hff00, 16'h0041};
      10: return {16'h00ff, 16'h0800};
      11: return {16'hc03f, 16'h0600};
      12: return {16'hf000, 16'h0208};
      13: return {16'hff00, 16'h0020};
      14: return {16'h00ff, 16'h4300};
      15: return {16'hc03f, 16'h3000};
      default: return {16'hffff, 16'h0000};
    endcase
  endfunction

  task automatic fail_and_stop();
    errors++;
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      fail_and_stop();
    end
  endtask

  // lock as sampled at this edge gives run, and run gives the cycle count.
  task automatic model_update();
    logic prev_run;
    logic rise;
    prev_run = m_run;
    rise     = m_cnt[num_stages-1] & ~m_cnt_last[num_stages-1];
    m_hi     = pll_lock ? ((m_hi < 2) ? m_hi + 1 : 2) : 0;
    m_run    = (m_hi >= 2);
    if (prev_run) begin
      if (rise) begin
        m_rises++;
        if (m_rises >= 2) begin
          m_rel = 1'b1;
        end
      end
      m_cnt_last = m_cnt;
      m_cnt      = m_cnt + 1;
    end else begin
      m_rises    = 0;
      m_rel      = 1'b0;
      m_cnt_last = 0;
      m_cnt      = 0;
    end
  endtask

  task automatic pll_update();
    drp_rsp = '0;
    if (pend > 0) begin
      pend--;
      if (pend == 0) begin
        drp_rsp.drdy = 1'b1;
        drp_rsp.dout = pend_dout;
        if (pend_we) begin
          pll_regs[pend_addr] = pend_di;
        end
      end
    end
    if (drp_req.den) begin
      assert (pend == 0 && !drp_rsp.drdy) else begin
        $display("a DRP access was issued before the previous one was answered");
        fail_and_stop();
      end
      pend      = 1 + rand_bits(2);
      pend_we   = drp_req.dwe;
      pend_addr = drp_req.daddr;
      pend_di   = drp_req.di;
      pend_dout = pll_regs[drp_req.daddr];
      den_cnt++;
    end
    // lock drops during reset and returns after a fixed delay.
    if (rst_pll) begin
      lock_cnt = 0;
    end else if (lock_cnt < lock_delay) begin
      lock_cnt++;
    end
    pll_lock = !rst_pll && (lock_cnt >= lock_delay);
  endtask

  task automatic step_cycle();
    @(posedge CLKS);
    #0.5;
    cyc++;
    assert (cyc < max_cycles) else begin
      $display("timeout with the test still running after %0d cycles", cyc);
      fail_and_stop();
    end
    cfg_chg = 1'b0;
    model_update();
    check_value("run", run, m_run);
    check_value("div_lvl", div_lvl, stage_lvl_t'(m_cnt));
    check_value("rstx_slow", rstx_slow, m_rel & m_run);
    assert (dut.u_drp_seq.u_chk.fail_cnt == 0) else begin
      $display("a concurrent assertion on the DRP port or the PLL reset failed");
      fail_and_stop();
    end
    pll_update();
  endtask

  task automatic issue_strobe(input int c);
    logic      idle_now;
    logic [31:0] e;
    int        addr;
    idle_now = !cfg_busy;
    cfg_sel  = cfg_sel_t'(c);
    cfg_chg  = 1'b1;
    if (idle_now) begin
      accepted++;
      for (int k = 0; k < num_reg; k++) begin
        addr         = rom_base + k;
        e            = table_entry(c, k);
        m_regs[addr] = (m_regs[addr] & e[31:16]) | e[15:0];
      end
    end
    step_cycle();
    if (idle_now) begin
      check_value("cfg_busy", cfg_busy, 1'b1);
      check_value("rst_pll", rst_pll, 1'b1);
    end
  endtask

  task automatic compare_regs();
    for (int a = 0; a < 32; a++) begin
      check_value($sformatf("pll_regs[%0d]", a), pll_regs[a], m_regs[a]);
    end
    check_value("DRP access count", den_cnt, 2 * num_reg * accepted);
  endtask

  initial begin
    CLKS      = 1'b0;
    RSTXS     = 1'b0;
    pll_lock  = 1'b0;
    cfg_sel   = '0;
    cfg_chg   = 1'b0;
    drp_rsp   = '0;
    lfsr      = 32'h5cca_72f6;
    cyc       = 0;
    errors    = 0;
    pend      = 0;
    pend_we   = 1'b0;
    pend_addr = '0;
    pend_di   = '0;
    pend_dout = '0;
    lock_cnt  = 0;
    den_cnt   = 0;
    m_hi      = 0;
    m_run     = 1'b0;
    m_cnt     = 0;
    m_cnt_last = 0;
    m_rises   = 0;
    m_rel     = 1'b0;
    accepted  = 0;
    for (int a = 0; a < 32; a++) begin
      pll_regs[a] = drp_data_t'(rand_bits(drp_dw));
      m_regs[a]   = pll_regs[a];
    end
    repeat (reset_cycles) @(posedge CLKS);
    #0.5;
    RSTXS = 1'b1;
    check_value("den", drp_req.den, 1'b0);
    check_value("dwe", drp_req.dwe, 1'b0);
    check_value("rst_pll", rst_pll, 1'b0);
    check_value("cfg_busy", cfg_busy, 1'b0);
    check_value("run", run, 1'b0);
    check_value("div_lvl", div_lvl, '0);
    check_value("rstx_slow", rstx_slow, 1'b0);
    while (!run) begin
      step_cycle();
    end
    repeat (div_cycles) step_cycle();
    for (int n = 0; n < num_reconf; n++) begin
      repeat (rand_bits(7)) step_cycle();
      issue_strobe(rand_bits(2));
      // a second strobe lands while the sequence is busy.
      if (rand_bits(1) != 0) begin
        repeat (1 + rand_bits(3)) step_cycle();
        issue_strobe(rand_bits(2));
      end
      while (cfg_busy) begin
        step_cycle();
      end
      compare_regs();
    end
    repeat (tail_cycles) step_cycle();
    if (errors == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      fail_and_stop();
    end
  end

endmodule

`default_nettype wire

// File: flist.f
clk_pkg.sv
lock_sync.sv
div_stage.sv
slow_rst_gen.sv
drp_rom.sv
drp_seq.sv
clk_rst_ctrl.sv
clk_rst_ctrl_chk.sv
tb_clk_rst_ctrl.sv
